// ==== bench/accel_sva.sv ====
/*
 * Accelerator assertions
 * Run status and response handshake rules, bound to the top level
 */
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_sva (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     o_busy,
    input wire                     o_done,
    input wire                     o_tx_valid,
    input wire                     i_tx_ready,
    input wire [`ACCEL_BYTE_W-1:0] o_tx_byte
);

    // Done comes after the last accumulation, never during a run
    assert property (@(posedge clk) disable iff (!rst_n) !(o_busy && o_done))
        else $error("busy and done are high in the same cycle");

    // Stalled byte must not change
    assert property (@(posedge clk) disable iff (!rst_n)
                     (o_tx_valid && !i_tx_ready) |=> $stable(o_tx_byte))
        else $error("response byte changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n) o_done |=> !o_done)
        else $error("done pulse lasted more than one cycle");

endmodule

bind accel_top accel_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .o_busy     (o_busy),
    .o_done     (o_done),
    .o_tx_valid (o_tx_valid),
    .i_tx_ready (i_tx_ready),
    .o_tx_byte  (o_tx_byte)
);

`default_nettype wire

// ==== bench/accel_tb.sv ====
/*
 * Accelerator testbench
 * Random host packets against a reference model of buffers, CSRs and sums
 */
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_tb
    import accel_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    // Worst-case packet plus response, times the packets of the run
    localparam int MAX_PACKETS = 160;
    localparam int PKT_CYCLES  = 120;
    localparam int CYCLE_LIMIT = MAX_PACKETS * PKT_CYCLES + 800;

    logic                     clk;
    logic                     rst_n;
    logic [`ACCEL_BYTE_W-1:0] rx_byte;
    logic                     rx_valid;
    logic                     tx_ready;
    wire  [`ACCEL_BYTE_W-1:0] tx_byte;
    wire                      tx_valid;
    wire                      busy;
    wire                      done;
    wire                      error;

    // Reference model
    logic [2*`ACCEL_LANE_W-1:0] model_a [`ACCEL_BUF_DEPTH];
    logic [2*`ACCEL_LANE_W-1:0] model_b [`ACCEL_BUF_DEPTH];
    logic [`ACCEL_KLEN_W-1:0]   model_klen;
    logic [`ACCEL_WORD_W-1:0]   model_runs;
    logic                       model_err;
    acc_set_t                   model_acc;

    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    test_err_base = 0;
    int    cycle_cnt = 0;
    int    done_seen = 0;
    int    seed_val;
    string test_name;

    accel_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rx_byte  (rx_byte),
        .i_rx_valid (rx_valid),
        .o_tx_byte  (tx_byte),
        .o_tx_valid (tx_valid),
        .i_tx_ready (tx_ready),
        .o_busy     (busy),
        .o_done     (done),
        .o_error    (error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (done) begin
            done_seen = done_seen + 1;
        end
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_word(input logic [`ACCEL_WORD_W-1:0] got,
                              input logic [`ACCEL_WORD_W-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_header(input logic [`ACCEL_BYTE_W-1:0] got,
                                input logic [`ACCEL_BYTE_W-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_acc(input acc_set_t got, input acc_set_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h %h %h %h expected %h %h %h %h",
                     $time, what, got.c00, got.c01, got.c10, got.c11,
                     exp.c00, exp.c01, exp.c10, exp.c11);
        end
    endtask

    // ==============================
    // Host link drivers
    // ==============================
    task automatic send_packet(input logic [7:0] cmd_byte, input logic [15:0] addr,
                               input logic [31:0] data, input int max_gap);
        logic [7:0] pkt [`ACCEL_PKT_BYTES];
        int         gap;
        pkt[0] = cmd_byte;
        pkt[1] = addr[7:0];
        pkt[2] = addr[15:8];
        pkt[3] = data[7:0];
        pkt[4] = data[15:8];
        pkt[5] = data[23:16];
        pkt[6] = data[31:24];
        for (int i = 0; i < `ACCEL_PKT_BYTES; i++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) begin
                @(posedge clk);
                #2;
                rx_valid = 1'b0;
            end
            @(posedge clk);
            #2;
            rx_byte  = pkt[i];
            rx_valid = 1'b1;
        end
        @(posedge clk);
        #2;
        rx_valid = 1'b0;
    endtask

    // Ready is high about 60% of the cycles
    task automatic collect_response(output logic [7:0] hdr, output logic [31:0] word);
        logic [7:0] got [5];
        int         count;
        count = 0;
        while (count < 5) begin
            @(posedge clk);
            #2;
            tx_ready = ($urandom_range(9, 0) < 6);
            @(negedge clk);
            if (tx_valid && tx_ready) begin
                got[count] = tx_byte;
                count++;
            end
        end
        @(posedge clk);
        #2;
        tx_ready = 1'b0;
        hdr  = got[0];
        word = {got[4], got[3], got[2], got[1]};
    endtask

    task automatic issue(input opcode_e op, input logic [15:0] addr, input logic [31:0] data);
        send_packet({op, 4'($urandom_range(15, 0))}, addr, data, 3);
    endtask

    task automatic request(input opcode_e op, input logic [15:0] addr,
                           output logic [31:0] word);
        logic [7:0] cmd_byte;
        logic [7:0] hdr;
        cmd_byte = {op, 4'($urandom_range(15, 0))};
        send_packet(cmd_byte, addr, $urandom, 3);
        collect_response(hdr, word);
        check_header(hdr, cmd_byte, "response header");
    endtask

    // ==============================
    // Model helpers
    // ==============================
    function automatic logic [31:0] model_csr_read(input logic [15:0] addr);
        case (addr)
            `ACCEL_CSR_KLEN:  return {27'd0, model_klen};
            `ACCEL_CSR_DONES: return model_runs;
            default:          return 32'd0;
        endcase
    endfunction

    function automatic acc_set_t model_sums(input int klen);
        acc_set_t          s;
        logic signed [7:0] a0;
        logic signed [7:0] a1;
        logic signed [7:0] b0;
        logic signed [7:0] b1;
        int                p00;
        int                p01;
        int                p10;
        int                p11;
        s = '0;
        for (int k = 0; k < klen; k++) begin
            a0 = model_a[k][7:0];
            a1 = model_a[k][15:8];
            b0 = model_b[k][7:0];
            b1 = model_b[k][15:8];
            p00 = a0 * b0;
            p01 = a0 * b1;
            p10 = a1 * b0;
            p11 = a1 * b1;
            s.c00 = s.c00 + p00;
            s.c01 = s.c01 + p01;
            s.c10 = s.c10 + p10;
            s.c11 = s.c11 + p11;
        end
        return s;
    endfunction

    task automatic write_klen(input logic [31:0] data);
        issue(CSR_WR, `ACCEL_CSR_KLEN, data);
        model_klen = (data[4:0] > 5'd16) ? 5'd16 : data[4:0];
    endtask

    task automatic read_csr_check(input logic [15:0] addr, input string what);
        logic [31:0] word;
        request(CSR_RD, addr, word);
        check_word(word, model_csr_read(addr), what);
    endtask

    task automatic read_status_check();
        logic [31:0] word;
        request(STATUS, 16'($urandom), word);
        check_word(word, {30'd0, model_err, 1'b0}, "status word");
        check_word({31'd0, error}, {31'd0, model_err}, "error output");
    endtask

    // Busy must last exactly K_LEN cycles before the done pulse
    task automatic run_and_check(input logic fill);
        int          busy_cycles;
        logic        seen;
        logic [31:0] word;
        acc_set_t    got;
        if (fill) begin
            for (int k = 0; k < `ACCEL_BUF_DEPTH; k++) begin
                model_a[k] = 16'($urandom);
                model_b[k] = 16'($urandom);
                issue(BUF_WR_A, {12'($urandom), 4'(k)}, {16'($urandom), model_a[k]});
                issue(BUF_WR_B, {12'($urandom), 4'(k)}, {16'($urandom), model_b[k]});
            end
        end
        issue(START, 16'($urandom), $urandom);
        model_acc = model_sums(model_klen);
        busy_cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (busy) begin
                busy_cycles++;
            end
            seen = done;
        end
        check_word(busy_cycles, model_klen, "busy cycles");
        model_runs = model_runs + 1;
        request(BUF_RD_OUT, {14'($urandom), 2'd0}, word);
        got.c00 = word;
        request(BUF_RD_OUT, {14'($urandom), 2'd1}, word);
        got.c01 = word;
        request(BUF_RD_OUT, {14'($urandom), 2'd2}, word);
        got.c10 = word;
        request(BUF_RD_OUT, {14'($urandom), 2'd3}, word);
        got.c11 = word;
        check_acc(got, model_acc, "result tile");
        read_csr_check(`ACCEL_CSR_DONES, "done count");
        read_status_check();
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        $display("test %0d %s: %s", tests_run, test_name,
                 (errors == test_err_base) ? "ok" : "failed");
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int base_dones;
        seed_val   = $urandom(32'hb2b0);
        rst_n      = 1'b0;
        rx_byte    = '0;
        rx_valid   = 1'b0;
        tx_ready   = 1'b0;
        model_klen = 5'd1;
        model_runs = '0;
        model_err  = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start_test("csr access");
        read_csr_check(`ACCEL_CSR_KLEN, "k_len after reset");
        for (int i = 0; i < 4; i++) begin
            write_klen($urandom);
            read_csr_check(`ACCEL_CSR_KLEN, "k_len readback");
        end
        // Values above the buffer depth clip to 16
        write_klen({27'($urandom), 5'($urandom_range(31, 17))});
        read_csr_check(`ACCEL_CSR_KLEN, "k_len saturated");
        // Counter is read-only
        issue(CSR_WR, `ACCEL_CSR_DONES, $urandom);
        read_csr_check(`ACCEL_CSR_DONES, "done count after write");
        read_csr_check(16'($urandom_range(65535, 2)), "unused csr");
        finish_test();

        start_test("mac runs");
        for (int r = 0; r < 2; r++) begin
            write_klen($urandom_range(16, 1));
            run_and_check(1'b1);
        end
        finish_test();

        start_test("empty run");
        write_klen(32'd0);
        run_and_check(1'b0);
        finish_test();

        start_test("abort");
        write_klen(32'd16);
        issue(START, 16'($urandom), $urandom);
        repeat (2) @(posedge clk);
        base_dones = done_seen;
        send_packet({ABORT, 4'($urandom_range(15, 0))}, 16'($urandom), $urandom, 0);
        check_word({31'd0, busy}, 32'd1, "busy before abort");
        repeat (40) @(negedge clk);
        @(posedge clk);
        #2;
        check_word({31'd0, busy}, 32'd0, "busy after abort");
        check_word(done_seen, base_dones, "done pulses after abort");
        read_csr_check(`ACCEL_CSR_DONES, "done count after abort");
        read_status_check();
        finish_test();

        start_test("illegal command");
        for (int i = 0; i < 2; i++) begin
            send_packet({4'($urandom_range(15, 8)), 4'($urandom_range(15, 0))},
                        `ACCEL_CSR_KLEN, $urandom, 3);
            model_err = 1'b1;
            repeat (20) begin
                @(negedge clk);
                if (tx_valid) begin
                    errors++;
                    $display("error at %0t: a response was sent for an illegal command",
                             $time);
                end
            end
        end
        read_status_check();
        read_csr_check(`ACCEL_CSR_KLEN, "k_len after illegal command");
        write_klen($urandom);
        read_csr_check(`ACCEL_CSR_KLEN, "k_len write after illegal command");
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/accel_settings.svh ====
/*
 * Accelerator settings
 * Widths, depths, packet length and CSR map of the packet command path
 */
`ifndef ACCEL_SETTINGS_SVH
`define ACCEL_SETTINGS_SVH

// Datapath widths
`define ACCEL_BYTE_W     8
`define ACCEL_WORD_W     32
`define ACCEL_LANE_W     8
`define ACCEL_ACC_W      32

// Operand buffers
`define ACCEL_BUF_DEPTH  16
`define ACCEL_BUF_AW     4
`define ACCEL_KLEN_W     5

// CSR map
`define ACCEL_CSR_KLEN   16'h0000
`define ACCEL_CSR_DONES  16'h0001

// Host packet: cmd, addr lo, addr hi, data0..data3
`define ACCEL_PKT_BYTES  7

`endif

// ==== rtl/accel_pkg.sv ====
/*
 * Accelerator types
 * Opcodes, executor states, decoded command and result set
 */
`default_nettype none

`include "accel_settings.svh"

package accel_pkg;

    // ==============================
    // Enumerations
    // ==============================

    // Command type, taken from the high nibble of the command byte
    typedef enum logic [3:0] {
        CSR_WR     = 4'h0,
        CSR_RD     = 4'h1,
        BUF_WR_A   = 4'h2,
        BUF_WR_B   = 4'h3,
        BUF_RD_OUT = 4'h4,
        START      = 4'h5,
        ABORT      = 4'h6,
        STATUS     = 4'h7
    } opcode_e;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } exec_state_e;

    // ==============================
    // Structures
    // ==============================

    // One decoded packet, valid for a single cycle
    typedef struct packed {
        logic                       valid;
        opcode_e                    opcode;
        logic [`ACCEL_BYTE_W-1:0]   cmd_byte;
        logic [2*`ACCEL_BYTE_W-1:0] addr;
        logic [`ACCEL_WORD_W-1:0]   data;
    } cmd_t;

    // 2x2 result tile, row index first
    typedef struct packed {
        logic signed [`ACCEL_ACC_W-1:0] c00;
        logic signed [`ACCEL_ACC_W-1:0] c01;
        logic signed [`ACCEL_ACC_W-1:0] c10;
        logic signed [`ACCEL_ACC_W-1:0] c11;
    } acc_set_t;

endpackage

`default_nettype wire

// ==== rtl/accel_top.sv ====
/*
 * Accelerator top level
 * Decode, execute and response stages of the host packet path
 */
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_top
    import accel_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [`ACCEL_BYTE_W-1:0]  i_rx_byte,
    input  wire                      i_rx_valid,
    output logic [`ACCEL_BYTE_W-1:0] o_tx_byte,
    output logic                     o_tx_valid,
    input  wire                      i_tx_ready,
    output logic                     o_busy,
    output logic                     o_done,
    output logic                     o_error
);

    cmd_t                     cmd;
    logic [`ACCEL_KLEN_W-1:0] k_len;
    logic [`ACCEL_WORD_W-1:0] csr_rdata;
    acc_set_t                 acc;

    packet_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rx_byte  (i_rx_byte),
        .i_rx_valid (i_rx_valid),
        .o_cmd      (cmd),
        .o_error    (o_error)
    );

    csr_bank u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd       (cmd),
        .i_done      (o_done),
        .o_k_len     (k_len),
        .o_csr_rdata (csr_rdata)
    );

    mac_executor u_exec (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_cmd   (cmd),
        .i_k_len (k_len),
        .o_busy  (o_busy),
        .o_done  (o_done),
        .o_acc   (acc)
    );

    response_serializer u_resp (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd       (cmd),
        .i_csr_rdata (csr_rdata),
        .i_acc       (acc),
        .i_busy      (o_busy),
        .i_error     (o_error),
        .o_tx_byte   (o_tx_byte),
        .o_tx_valid  (o_tx_valid),
        .i_tx_ready  (i_tx_ready)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_bank.sv ====
/*
 * CSR bank
 * K_LEN register, completed-run counter and CSR read mux
 */
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module csr_bank
    import accel_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire cmd_t                i_cmd,
    input  wire                      i_done,
    output logic [`ACCEL_KLEN_W-1:0] o_k_len,
    output logic [`ACCEL_WORD_W-1:0] o_csr_rdata
);

    logic [`ACCEL_KLEN_W-1:0] wr_klen;
    logic [`ACCEL_WORD_W-1:0] done_cnt_q;

    // Five data bits, clipped to the buffer depth
    assign wr_klen = (i_cmd.data[`ACCEL_KLEN_W-1:0] > `ACCEL_KLEN_W'(`ACCEL_BUF_DEPTH))
                   ? `ACCEL_KLEN_W'(`ACCEL_BUF_DEPTH)
                   : i_cmd.data[`ACCEL_KLEN_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_k_len    <= `ACCEL_KLEN_W'(1);
            done_cnt_q <= '0;
        end else begin
            if (i_cmd.valid && i_cmd.opcode == CSR_WR && i_cmd.addr == `ACCEL_CSR_KLEN) begin
                o_k_len <= wr_klen;
            end
            if (i_done) begin
                done_cnt_q <= done_cnt_q + 1'b1;
            end
        end
    end

    // Read data follows the command address
    always_comb begin
        case (i_cmd.addr)
            `ACCEL_CSR_KLEN:  o_csr_rdata = {{(`ACCEL_WORD_W-`ACCEL_KLEN_W){1'b0}}, o_k_len};
            `ACCEL_CSR_DONES: o_csr_rdata = done_cnt_q;
            default:          o_csr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mac_executor.sv ====
/*
 * MAC executor
 * Operand buffers A and B, run sequencer and 2x2 multiply-accumulate
 */
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module mac_executor
    import accel_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire cmd_t                i_cmd,
    input  wire [`ACCEL_KLEN_W-1:0]  i_k_len,
    output logic                     o_busy,
    output logic                     o_done,
    output acc_set_t                 o_acc
);

    logic [2*`ACCEL_LANE_W-1:0]        buf_a [`ACCEL_BUF_DEPTH];
    logic [2*`ACCEL_LANE_W-1:0]        buf_b [`ACCEL_BUF_DEPTH];
    exec_state_e                       state_q;
    logic [`ACCEL_KLEN_W-1:0]          k_q;
    logic [`ACCEL_KLEN_W-1:0]          run_len_q;
    logic [2*`ACCEL_LANE_W-1:0]        a_word;
    logic [2*`ACCEL_LANE_W-1:0]        b_word;
    logic signed [`ACCEL_LANE_W-1:0]   a0;
    logic signed [`ACCEL_LANE_W-1:0]   a1;
    logic signed [`ACCEL_LANE_W-1:0]   b0;
    logic signed [`ACCEL_LANE_W-1:0]   b1;
    logic signed [2*`ACCEL_LANE_W-1:0] p00;
    logic signed [2*`ACCEL_LANE_W-1:0] p01;
    logic signed [2*`ACCEL_LANE_W-1:0] p10;
    logic signed [2*`ACCEL_LANE_W-1:0] p11;
    logic                              start_req;
    logic                              abort_req;
    logic                              last_k;

    assign start_req = i_cmd.valid && (i_cmd.opcode == START);
    assign abort_req = i_cmd.valid && (i_cmd.opcode == ABORT);

    // ==============================
    // Operand buffers
    // ==============================
    always_ff @(posedge clk) begin
        if (i_cmd.valid && i_cmd.opcode == BUF_WR_A) begin
            buf_a[i_cmd.addr[`ACCEL_BUF_AW-1:0]] <= i_cmd.data[2*`ACCEL_LANE_W-1:0];
        end
        if (i_cmd.valid && i_cmd.opcode == BUF_WR_B) begin
            buf_b[i_cmd.addr[`ACCEL_BUF_AW-1:0]] <= i_cmd.data[2*`ACCEL_LANE_W-1:0];
        end
    end

    assign a_word = buf_a[k_q[`ACCEL_BUF_AW-1:0]];
    assign b_word = buf_b[k_q[`ACCEL_BUF_AW-1:0]];

    // Lane 0 in the low byte
    assign a0 = a_word[`ACCEL_LANE_W-1:0];
    assign a1 = a_word[2*`ACCEL_LANE_W-1:`ACCEL_LANE_W];
    assign b0 = b_word[`ACCEL_LANE_W-1:0];
    assign b1 = b_word[2*`ACCEL_LANE_W-1:`ACCEL_LANE_W];

    assign p00 = a0 * b0;
    assign p01 = a0 * b1;
    assign p10 = a1 * b0;
    assign p11 = a1 * b1;

    assign last_k = (k_q == run_len_q - 1'b1);

    // ==============================
    // Run sequencer
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            k_q       <= '0;
            run_len_q <= '0;
            o_done    <= 1'b0;
            o_acc     <= '0;
        end else begin
            o_done <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_req) begin
                        o_acc     <= '0;
                        k_q       <= '0;
                        run_len_q <= i_k_len;
                        // Empty run finishes at once
                        if (i_k_len == '0) begin
                            o_done <= 1'b1;
                        end else begin
                            state_q <= RUN;
                        end
                    end
                end
                RUN: begin
                    if (abort_req) begin
                        state_q <= IDLE;
                    end else begin
                        o_acc.c00 <= o_acc.c00 + p00;
                        o_acc.c01 <= o_acc.c01 + p01;
                        o_acc.c10 <= o_acc.c10 + p10;
                        o_acc.c11 <= o_acc.c11 + p11;
                        k_q       <= k_q + 1'b1;
                        if (last_k) begin
                            state_q <= IDLE;
                            o_done  <= 1'b1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign o_busy = (state_q == RUN);

endmodule

`default_nettype wire

// ==== rtl/packet_decoder.sv ====
/*
 * Packet decoder
 * Collects 7-byte host packets and issues one command pulse per packet
 */
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module packet_decoder
    import accel_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [`ACCEL_BYTE_W-1:0]  i_rx_byte,
    input  wire                      i_rx_valid,
    output cmd_t                     o_cmd,
    output logic                     o_error
);

    logic [2:0]                                 byte_cnt_q;
    logic [`ACCEL_BYTE_W-1:0]                   cmd_q;
    logic [2*`ACCEL_BYTE_W-1:0]                 addr_q;
    logic [`ACCEL_WORD_W-`ACCEL_BYTE_W-1:0]     data_q;
    logic                                       last_byte;
    logic                                       illegal;

    assign last_byte = i_rx_valid && (byte_cnt_q == 3'(`ACCEL_PKT_BYTES - 1));

    // Types 8 to F are not defined
    assign illegal = cmd_q[`ACCEL_BYTE_W-1];

    // ==============================
    // Byte assembly
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt_q  <= '0;
            o_cmd.valid <= 1'b0;
            o_error     <= 1'b0;
        end else begin
            o_cmd.valid <= 1'b0;
            if (i_rx_valid) begin
                if (last_byte) begin
                    byte_cnt_q <= '0;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                end

                case (byte_cnt_q)
                    3'd0: cmd_q <= i_rx_byte;
                    3'd1: addr_q[7:0] <= i_rx_byte;
                    3'd2: addr_q[15:8] <= i_rx_byte;
                    3'd3: data_q[7:0] <= i_rx_byte;
                    3'd4: data_q[15:8] <= i_rx_byte;
                    3'd5: data_q[23:16] <= i_rx_byte;
                    default: begin
                        // Seventh byte completes the packet
                        o_cmd.valid    <= !illegal;
                        o_cmd.opcode   <= opcode_e'(cmd_q[7:4]);
                        o_cmd.cmd_byte <= cmd_q;
                        o_cmd.addr     <= addr_q;
                        o_cmd.data     <= {i_rx_byte, data_q};
                        if (illegal) begin
                            o_error <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/response_serializer.sv ====
/*
 * Response serializer
 * Sends the echoed command byte and a 32-bit word, LSB first, under ready
 */
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module response_serializer
    import accel_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire cmd_t                i_cmd,
    input  wire [`ACCEL_WORD_W-1:0]  i_csr_rdata,
    input  wire acc_set_t            i_acc,
    input  wire                      i_busy,
    input  wire                      i_error,
    output logic [`ACCEL_BYTE_W-1:0] o_tx_byte,
    output logic                     o_tx_valid,
    input  wire                      i_tx_ready
);

    logic                       resp_req;
    logic [`ACCEL_WORD_W-1:0]   resp_word;
    logic [2:0]                 idx_q;
    logic [`ACCEL_BYTE_W-1:0]   hdr_q;
    logic [`ACCEL_WORD_W-1:0]   word_q;
    logic                       last_idx;

    assign resp_req = i_cmd.valid && (i_cmd.opcode inside {CSR_RD, STATUS, BUF_RD_OUT});
    assign last_idx = (idx_q == 3'(`ACCEL_WORD_W / `ACCEL_BYTE_W));

    // ==============================
    // Response word select
    // ==============================
    always_comb begin
        resp_word = '0;
        case (i_cmd.opcode)
            CSR_RD: resp_word = i_csr_rdata;
            STATUS: begin
                resp_word[0] = i_busy;
                resp_word[1] = i_error;
            end
            BUF_RD_OUT: begin
                case (i_cmd.addr[1:0])
                    2'd0: resp_word = i_acc.c00;
                    2'd1: resp_word = i_acc.c01;
                    2'd2: resp_word = i_acc.c10;
                    default: resp_word = i_acc.c11;
                endcase
            end
            default: resp_word = '0;
        endcase
    end

    // Requests that arrive mid-response are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_tx_valid <= 1'b0;
            idx_q      <= '0;
        end else if (!o_tx_valid) begin
            if (resp_req) begin
                o_tx_valid <= 1'b1;
                idx_q      <= '0;
                hdr_q      <= i_cmd.cmd_byte;
                word_q     <= resp_word;
            end
        end else if (i_tx_ready) begin
            if (last_idx) begin
                o_tx_valid <= 1'b0;
            end else begin
                idx_q <= idx_q + 3'd1;
            end
        end
    end

    // Header first, then data bytes LSB first
    always_comb begin
        case (idx_q)
            3'd0: o_tx_byte = hdr_q;
            3'd1: o_tx_byte = word_q[7:0];
            3'd2: o_tx_byte = word_q[15:8];
            3'd3: o_tx_byte = word_q[23:16];
            default: o_tx_byte = word_q[31:24];
        endcase
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/accel_pkg.sv
rtl/packet_decoder.sv
rtl/csr_bank.sv
rtl/mac_executor.sv
rtl/response_serializer.sv
rtl/accel_top.sv
bench/accel_sva.sv
bench/accel_tb.sv
